// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int WORD_W     = 16;
   localparam int REG_ADDR_W = 2;
   localparam int NUM_REGS   = 4;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   ////////////////////////////////////////
   // instruction fields
   ////////////////////////////////////////

   localparam int OP_HI   = 15;
   localparam int OP_LO   = 12;
   localparam int RS_HI   = 11;
   localparam int RS_LO   = 10;
   localparam int RT_HI   = 9;
   localparam int RT_LO   = 8;
   localparam int RD_HI   = 7;
   localparam int RD_LO   = 6;
   localparam int FUNC_HI = 5;
   localparam int FUNC_LO = 0;
   localparam int IMM_HI  = 7;
   localparam int IMM_LO  = 0;
   localparam int IMM_W   = IMM_HI - IMM_LO + 1;

   // opcodes handled by this core, the rest decode as no-op
   typedef enum logic [3:0] {
      OP_ADI   = 4'h4,
      OP_ORI   = 4'h5,
      OP_LHI   = 4'h6,
      OP_RTYPE = 4'hf
   } opcode_e;

   // r-type function codes
   typedef enum logic [5:0] {
      FN_ADD = 6'd0,
      FN_SUB = 6'd1,
      FN_AND = 6'd2,
      FN_ORR = 6'd3,
      FN_NOT = 6'd4,
      FN_TCP = 6'd5,
      FN_SHL = 6'd6,
      FN_SHR = 6'd7,
      FN_WWD = 6'd28,
      FN_HLT = 6'd29
   } func_e;

   ////////////////////////////////////////
   // execute controls
   ////////////////////////////////////////

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_ORR    = 4'd3,
      ALU_NOT    = 4'd4,
      ALU_TCP    = 4'd5,
      ALU_SHL    = 4'd6,
      ALU_SHR    = 4'd7,
      ALU_PASS_B = 4'd8
   } alu_op_e;

   // second alu operand
   typedef enum logic {
      SRC_B_REG = 1'b0,
      SRC_B_IMM = 1'b1
   } src_b_e;

   // value of registers and output port after reset
   localparam word_t RESET_WORD = 16'h0000;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
   input  cpu_pkg::alu_op_e i_op,
   input  cpu_pkg::word_t   i_a,
   input  cpu_pkg::word_t   i_b,
   output cpu_pkg::word_t   o_result
);
   import cpu_pkg::*;

   always_comb begin
      case (i_op)
         // add and sub wrap, no carry out
         ALU_ADD: o_result = i_a + i_b;
         ALU_SUB: o_result = i_a - i_b;

         // bitwise
         ALU_AND: o_result = i_a & i_b;
         ALU_ORR: o_result = i_a | i_b;

         // unary ops on operand a
         ALU_NOT: o_result = ~i_a;
         ALU_TCP: o_result = ~i_a + word_t'(1);

         // one-bit shifts
         ALU_SHL: o_result = {i_a[WORD_W-2:0], 1'b0};
         // arithmetic, sign bit kept
         ALU_SHR: o_result = {i_a[WORD_W-1], i_a[WORD_W-1:1]};

         // immediate pass for lhi
         ALU_PASS_B: o_result = i_b;

         default: o_result = '0;
      endcase
   end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
   input  logic               clk,
   input  logic               reset_n,
   input  cpu_pkg::reg_addr_t i_raddr1,
   input  cpu_pkg::reg_addr_t i_raddr2,
   input  logic               i_we,
   input  cpu_pkg::reg_addr_t i_waddr,
   input  cpu_pkg::word_t     i_wdata,
   output cpu_pkg::word_t     o_rdata1,
   output cpu_pkg::word_t     o_rdata2
);
   import cpu_pkg::*;

   word_t regs [NUM_REGS];

   // single write port, written from write-back
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= RESET_WORD;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // write-through
   // decode sees the value being written this cycle
   assign o_rdata1 = (i_we && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
   assign o_rdata2 = (i_we && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
   input  cpu_pkg::opcode_e i_opcode,
   input  cpu_pkg::func_e   i_func,
   output cpu_pkg::alu_op_e o_alu_op,
   output cpu_pkg::src_b_e  o_src_b,
   output logic             o_reg_write,
   output logic             o_dst_is_rd,
   output logic             o_sign_ext,
   output logic             o_lhi,
   output logic             o_wwd,
   output logic             o_hlt
);
   import cpu_pkg::*;

   always_comb begin
      // defaults give a no-op
      o_alu_op    = ALU_ADD;
      o_src_b     = SRC_B_REG;
      o_reg_write = 1'b0;
      o_dst_is_rd = 1'b0;
      o_sign_ext  = 1'b0;
      o_lhi       = 1'b0;
      o_wwd       = 1'b0;
      o_hlt       = 1'b0;

      case (i_opcode)
         // immediate forms all write rt
         OP_ADI: begin
            o_alu_op    = ALU_ADD;
            o_src_b     = SRC_B_IMM;
            o_reg_write = 1'b1;
            o_sign_ext  = 1'b1;
         end
         OP_ORI: begin
            o_alu_op    = ALU_ORR;
            o_src_b     = SRC_B_IMM;
            o_reg_write = 1'b1;
         end
         OP_LHI: begin
            // immediate already shifted up, alu just passes it
            o_alu_op    = ALU_PASS_B;
            o_src_b     = SRC_B_IMM;
            o_reg_write = 1'b1;
            o_lhi       = 1'b1;
         end
         OP_RTYPE: begin
            case (i_func)
               FN_ADD, FN_SUB, FN_AND, FN_ORR,
               FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                  // function code and alu op share the low bits
                  o_alu_op    = alu_op_e'({1'b0, i_func[2:0]});
                  o_reg_write = 1'b1;
                  o_dst_is_rd = 1'b1;
               end
               // output port write of rs
               FN_WWD:  o_wwd = 1'b1;
               FN_HLT:  o_hlt = 1'b1;
               default: o_wwd = 1'b0;
            endcase
         end
         // unsupported opcode
         default: o_reg_write = 1'b0;
      endcase
   end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
   input  logic               clk,
   input  logic               reset_n,
   input  cpu_pkg::word_t     i_inst,
   input  logic               i_inst_valid,
   input  logic               i_halted,
   input  logic               i_wb_we,
   input  cpu_pkg::reg_addr_t i_wb_addr,
   input  cpu_pkg::word_t     i_wb_data,
   output logic               o_ex_valid,
   output cpu_pkg::alu_op_e   o_ex_alu_op,
   output cpu_pkg::src_b_e    o_ex_src_b,
   output logic               o_ex_reg_write,
   output cpu_pkg::reg_addr_t o_ex_dst,
   output cpu_pkg::reg_addr_t o_ex_rs,
   output cpu_pkg::reg_addr_t o_ex_rt,
   output cpu_pkg::word_t     o_ex_a,
   output cpu_pkg::word_t     o_ex_b,
   output cpu_pkg::word_t     o_ex_imm,
   output logic               o_ex_wwd,
   output logic               o_ex_hlt
);
   import cpu_pkg::*;

   word_t             inst_q;
   logic              inst_valid_q;
   opcode_e           opcode;
   func_e             func;
   reg_addr_t         rs;
   reg_addr_t         rt;
   reg_addr_t         rd;
   logic [IMM_W-1:0]  imm8;
   word_t             imm_ext;
   word_t             rdata1;
   word_t             rdata2;
   alu_op_e           dec_alu_op;
   src_b_e            dec_src_b;
   logic              dec_reg_write;
   logic              dec_dst_is_rd;
   logic              dec_sign_ext;
   logic              dec_lhi;
   logic              dec_wwd;
   logic              dec_hlt;

   ////////////////////////////////////////
   // instruction latch
   ////////////////////////////////////////

   // nothing new is taken once halted
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         inst_valid_q <= 1'b0;
      end else begin
         inst_valid_q <= i_inst_valid && !i_halted;
      end
   end

   always_ff @(posedge clk) begin
      if (i_inst_valid) begin
         inst_q <= i_inst;
      end
   end

   // field split
   assign opcode = opcode_e'(inst_q[OP_HI:OP_LO]);
   assign func   = func_e'(inst_q[FUNC_HI:FUNC_LO]);
   assign rs     = inst_q[RS_HI:RS_LO];
   assign rt     = inst_q[RT_HI:RT_LO];
   assign rd     = inst_q[RD_HI:RD_LO];
   assign imm8   = inst_q[IMM_HI:IMM_LO];

   // adi sign-extends, ori zero-extends, lhi goes to the high byte
   assign imm_ext = dec_lhi      ? {imm8, {(WORD_W-IMM_W){1'b0}}} :
                    dec_sign_ext ? {{(WORD_W-IMM_W){imm8[IMM_W-1]}}, imm8} :
                                   {{(WORD_W-IMM_W){1'b0}}, imm8};

   inst_decoder u_dec (
      .i_opcode    (opcode),
      .i_func      (func),
      .o_alu_op    (dec_alu_op),
      .o_src_b     (dec_src_b),
      .o_reg_write (dec_reg_write),
      .o_dst_is_rd (dec_dst_is_rd),
      .o_sign_ext  (dec_sign_ext),
      .o_lhi       (dec_lhi),
      .o_wwd       (dec_wwd),
      .o_hlt       (dec_hlt)
   );

   // rs on port 1, rt on port 2
   reg_file u_rf (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_raddr1 (rs),
      .i_raddr2 (rt),
      .i_we     (i_wb_we),
      .i_waddr  (i_wb_addr),
      .i_wdata  (i_wb_data),
      .o_rdata1 (rdata1),
      .o_rdata2 (rdata2)
   );

   ////////////////////////////////////////
   // decode to execute
   ////////////////////////////////////////

   // bubble clears valid and enables
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_ex_valid     <= 1'b0;
         o_ex_alu_op    <= ALU_ADD;
         o_ex_src_b     <= SRC_B_REG;
         o_ex_reg_write <= 1'b0;
         o_ex_wwd       <= 1'b0;
         o_ex_hlt       <= 1'b0;
      end else begin
         o_ex_valid     <= inst_valid_q;
         o_ex_alu_op    <= dec_alu_op;
         o_ex_src_b     <= dec_src_b;
         o_ex_reg_write <= inst_valid_q && dec_reg_write;
         o_ex_wwd       <= inst_valid_q && dec_wwd;
         o_ex_hlt       <= inst_valid_q && dec_hlt;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      o_ex_dst <= dec_dst_is_rd ? rd : rt;
      o_ex_rs  <= rs;
      o_ex_rt  <= rt;
      o_ex_a   <= rdata1;
      o_ex_b   <= rdata2;
      o_ex_imm <= imm_ext;
   end

endmodule

// ==== hw/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
   input  logic               clk,
   input  logic               reset_n,
   input  logic               i_ex_valid,
   input  cpu_pkg::alu_op_e   i_ex_alu_op,
   input  cpu_pkg::src_b_e    i_ex_src_b,
   input  logic               i_ex_reg_write,
   input  cpu_pkg::reg_addr_t i_ex_dst,
   input  cpu_pkg::reg_addr_t i_ex_rs,
   input  cpu_pkg::reg_addr_t i_ex_rt,
   input  cpu_pkg::word_t     i_ex_a,
   input  cpu_pkg::word_t     i_ex_b,
   input  cpu_pkg::word_t     i_ex_imm,
   input  logic               i_ex_wwd,
   input  logic               i_ex_hlt,
   output logic               o_wb_we,
   output cpu_pkg::reg_addr_t o_wb_addr,
   output cpu_pkg::word_t     o_wb_data,
   output cpu_pkg::word_t     o_output_port,
   output logic               o_output_write,
   output logic               o_halted
);
   import cpu_pkg::*;

   logic      wb_we_q;
   reg_addr_t wb_addr_q;
   word_t     wb_data_q;
   word_t     port_q;
   logic      port_wr_q;
   logic      halted_q;
   logic      ex_live;
   logic      fwd_a_hit;
   logic      fwd_b_hit;
   word_t     opnd_a;
   word_t     opnd_b;
   word_t     alu_b;
   word_t     alu_result;

   // instruction in flight after hlt is dropped here
   assign ex_live = i_ex_valid && !halted_q;

   ////////////////////////////////////////
   // forwarding
   ////////////////////////////////////////

   // only source is the write-back register
   // older results come through the register file
   assign fwd_a_hit = wb_we_q && (wb_addr_q == i_ex_rs);
   assign fwd_b_hit = wb_we_q && (wb_addr_q == i_ex_rt);

   assign opnd_a = fwd_a_hit ? wb_data_q : i_ex_a;
   assign opnd_b = fwd_b_hit ? wb_data_q : i_ex_b;

   // reg or immediate into port b
   assign alu_b = (i_ex_src_b == SRC_B_IMM) ? i_ex_imm : opnd_b;

   alu u_alu (
      .i_op     (i_ex_alu_op),
      .i_a      (opnd_a),
      .i_b      (alu_b),
      .o_result (alu_result)
   );

   ////////////////////////////////////////
   // execute to write-back
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wb_we_q   <= 1'b0;
         port_wr_q <= 1'b0;
         port_q    <= RESET_WORD;
         halted_q  <= 1'b0;
      end else begin
         wb_we_q   <= ex_live && i_ex_reg_write;
         port_wr_q <= ex_live && i_ex_wwd;
         // wwd takes rs, forwarded like any operand
         if (ex_live && i_ex_wwd) begin
            port_q <= opnd_a;
         end
         // sticky until reset
         if (ex_live && i_ex_hlt) begin
            halted_q <= 1'b1;
         end
      end
   end

   // result payload, qualified by wb_we_q
   always_ff @(posedge clk) begin
      wb_addr_q <= i_ex_dst;
      wb_data_q <= alu_result;
   end

   assign o_wb_we        = wb_we_q;
   assign o_wb_addr      = wb_addr_q;
   assign o_wb_data      = wb_data_q;
   assign o_output_port  = port_q;
   assign o_output_write = port_wr_q;
   assign o_halted       = halted_q;

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
   input  logic           clk,
   input  logic           reset_n,
   input  cpu_pkg::word_t i_inst,
   input  logic           i_inst_valid,
   output cpu_pkg::word_t o_output_port,
   output logic           o_output_write,
   output logic           o_halted
);
   import cpu_pkg::*;

   ////////////////////////////////////////
   // decode to execute
   ////////////////////////////////////////

   logic      ex_valid;
   alu_op_e   ex_alu_op;
   src_b_e    ex_src_b;
   logic      ex_reg_write;
   reg_addr_t ex_dst;
   reg_addr_t ex_rs;
   reg_addr_t ex_rt;
   word_t     ex_a;
   word_t     ex_b;
   word_t     ex_imm;
   logic      ex_wwd;
   logic      ex_hlt;

   // write-back path to the register file
   logic      wb_we;
   reg_addr_t wb_addr;
   word_t     wb_data;

   id_stage u_id (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_inst         (i_inst),
      .i_inst_valid   (i_inst_valid),
      .i_halted       (o_halted),
      .i_wb_we        (wb_we),
      .i_wb_addr      (wb_addr),
      .i_wb_data      (wb_data),
      .o_ex_valid     (ex_valid),
      .o_ex_alu_op    (ex_alu_op),
      .o_ex_src_b     (ex_src_b),
      .o_ex_reg_write (ex_reg_write),
      .o_ex_dst       (ex_dst),
      .o_ex_rs        (ex_rs),
      .o_ex_rt        (ex_rt),
      .o_ex_a         (ex_a),
      .o_ex_b         (ex_b),
      .o_ex_imm       (ex_imm),
      .o_ex_wwd       (ex_wwd),
      .o_ex_hlt       (ex_hlt)
   );

   exec_stage u_ex (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_ex_valid     (ex_valid),
      .i_ex_alu_op    (ex_alu_op),
      .i_ex_src_b     (ex_src_b),
      .i_ex_reg_write (ex_reg_write),
      .i_ex_dst       (ex_dst),
      .i_ex_rs        (ex_rs),
      .i_ex_rt        (ex_rt),
      .i_ex_a         (ex_a),
      .i_ex_b         (ex_b),
      .i_ex_imm       (ex_imm),
      .i_ex_wwd       (ex_wwd),
      .i_ex_hlt       (ex_hlt),
      .o_wb_we        (wb_we),
      .o_wb_addr      (wb_addr),
      .o_wb_data      (wb_data),
      .o_output_port  (o_output_port),
      .o_output_write (o_output_write),
      .o_halted       (o_halted)
   );

endmodule

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////////////
// isa reference
////////////////////////////////////////

// runs one instruction on ref_regs, returns 1 for a wwd
function automatic bit ref_execute(input word_t inst, output word_t wwd_val, output bit is_hlt);
   logic [3:0] op;
   logic [5:0] fn;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   word_t      a;
   word_t      b;
   bit         is_wwd;
   // field positions straight from the isa
   op      = inst[15:12];
   rs      = inst[11:10];
   rt      = inst[9:8];
   rd      = inst[7:6];
   fn      = inst[5:0];
   a       = ref_regs[rs];
   b       = ref_regs[rt];
   is_wwd  = 1'b0;
   is_hlt  = 1'b0;
   wwd_val = 16'h0000;
   case (op)
      // immediates land in rt
      OP_ADI: ref_regs[rt] = a + {{8{inst[7]}}, inst[7:0]};
      OP_ORI: ref_regs[rt] = a | {8'h00, inst[7:0]};
      OP_LHI: ref_regs[rt] = {inst[7:0], 8'h00};
      OP_RTYPE: begin
         case (fn)
            FN_ADD: ref_regs[rd] = a + b;
            FN_SUB: ref_regs[rd] = a - b;
            FN_AND: ref_regs[rd] = a & b;
            FN_ORR: ref_regs[rd] = a | b;
            FN_NOT: ref_regs[rd] = ~a;
            FN_TCP: ref_regs[rd] = 16'h0000 - a;
            FN_SHL: ref_regs[rd] = a << 1;
            // arithmetic, sign kept
            FN_SHR: ref_regs[rd] = word_t'($signed(a) >>> 1);
            FN_WWD: begin
               is_wwd  = 1'b1;
               wwd_val = a;
            end
            FN_HLT: is_hlt = 1'b1;
            // unknown function, no effect
            default: is_wwd = 1'b0;
         endcase
      end
      // unknown opcode, no effect
      default: is_wwd = 1'b0;
   endcase
   return is_wwd;
endfunction

// plain 32-bit lcg step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
   return state * 32'd1664525 + 32'd1013904223;
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_word(input word_t got, input word_t exp, input string what);
   if (got !== exp) begin
      $display("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp);
      end_with_failure();
   end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
   if (got !== exp) begin
      $display("ERROR @ %0t: %s is %b, expected %b", $time, what, got, exp);
      end_with_failure();
   end
endtask

`endif

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
   import cpu_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int BODY_LEN     = 300;
   localparam int DRAIN_CYCLES = 12;

   logic  clk = 1'b0;
   logic  reset_n;
   word_t i_inst;
   logic  i_inst_valid;
   word_t o_output_port;
   logic  o_output_write;
   logic  o_halted;

   // model state for the reference
   word_t       ref_regs [NUM_REGS];
   bit          ref_halted;
   logic [31:0] lcg_state = 32'h710e_18e1;

   // program with one entry per driven cycle
   word_t prog_inst [$];
   bit    prog_valid [$];

   // wwd values and the cycle each one is due
   word_t exp_val_q [$];
   int    exp_cyc_q [$];
   word_t exp_port;
   int    halt_cyc = 32'h7fff_ffff;
   int    cyc = 0;
   int    cycle_limit = 1000000;

   `include "tb_ref_model.svh"

   cpu_top dut0 (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_inst         (i_inst),
      .i_inst_valid   (i_inst_valid),
      .o_output_port  (o_output_port),
      .o_output_write (o_output_write),
      .o_halted       (o_halted)
   );

   always #4 clk = ~clk;

   task automatic end_with_failure();
      $display("Verification failed");
      $fatal(1, "run stopped at the first error");
   endtask

   function automatic int rand_below(input int n);
      lcg_state = lcg_next(lcg_state);
      return int'(lcg_state[30:16]) % n;
   endfunction

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   // wwd about a quarter of the time and never hlt
   function automatic word_t random_inst();
      int         kind;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [7:0] imm;
      logic [3:0] op;
      word_t      inst;
      kind = rand_below(16);
      rs   = reg_addr_t'(rand_below(NUM_REGS));
      rt   = reg_addr_t'(rand_below(NUM_REGS));
      rd   = reg_addr_t'(rand_below(NUM_REGS));
      imm  = 8'(rand_below(256));
      op   = 4'(rand_below(16));
      if (kind < 4) begin
         inst = {OP_RTYPE, rs, rt, rd, FN_WWD};
      end else if (kind < 6) begin
         inst = {OP_ADI, rs, rt, imm};
      end else if (kind == 6) begin
         inst = {OP_ORI, rs, rt, imm};
      end else if (kind == 7) begin
         inst = {OP_LHI, rs, rt, imm};
      end else if (kind < 14) begin
         inst = {OP_RTYPE, rs, rt, rd, 6'(rand_below(8))};
      end else if (kind == 14) begin
         // opcode outside the supported set
         if (op inside {OP_ADI, OP_ORI, OP_LHI, OP_RTYPE}) begin
            op = 4'h0;
         end
         inst = {op, rs, rt, imm};
      end else begin
         // r-type with an unused function code
         inst = {OP_RTYPE, rs, rt, rd, 6'(8 + rand_below(20))};
      end
      return inst;
   endfunction

   function automatic void add_cycle(input word_t inst, input bit valid);
      prog_inst.push_back(inst);
      prog_valid.push_back(valid);
   endfunction

   task automatic build_program();
      int n;
      // reads before any write give zero
      for (int r = 0; r < NUM_REGS; r++) begin
         add_cycle({OP_RTYPE, reg_addr_t'(r), 2'd0, 2'd0, FN_WWD}, 1'b1);
      end
      // each alu op on operands made just before it
      for (int f = 0; f < 8; f++) begin
         add_cycle({OP_LHI, 2'd0, 2'd1, 8'(rand_below(256))}, 1'b1);
         add_cycle({OP_ADI, 2'd1, 2'd1, 8'(rand_below(256))}, 1'b1);
         add_cycle({OP_ORI, 2'd0, 2'd3, 8'(rand_below(256))}, 1'b1);
         add_cycle({OP_RTYPE, 2'd1, 2'd3, 2'd2, 6'(f)}, 1'b1);
         add_cycle({OP_RTYPE, 2'd2, 2'd0, 2'd0, FN_WWD}, 1'b1);
      end
      // random body where bubbles carry junk on i_inst
      n = 0;
      while (n < BODY_LEN) begin
         if (rand_below(4) == 0) begin
            add_cycle(random_inst(), 1'b0);
         end else begin
            add_cycle(random_inst(), 1'b1);
            n++;
         end
      end
      add_cycle({OP_RTYPE, 2'd0, 2'd0, 2'd0, FN_HLT}, 1'b1);
      // issued past the hlt and never seen on the outputs
      for (int i = 0; i < 3; i++) begin
         add_cycle({OP_ADI, 2'd0, 2'd0, 8'h5a}, 1'b1);
         add_cycle({OP_RTYPE, 2'd0, 2'd0, 2'd0, FN_WWD}, 1'b1);
      end
   endtask

   // cycle count and timeout
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= cycle_limit) begin
         $display("timeout: core did not halt within %0d cycles", cycle_limit);
         end_with_failure();
      end
   end

   ////////////////////////////////////////
   // driver and verdict
   ////////////////////////////////////////

   initial begin
      word_t wwd_val;
      bit    is_wwd;
      bit    is_hlt;
      reset_n      = 1'b0;
      i_inst       = 16'h0000;
      i_inst_valid = 1'b0;
      exp_port     = 16'h0000;
      for (int r = 0; r < NUM_REGS; r++) begin
         ref_regs[r] = 16'h0000;
      end
      build_program();
      cycle_limit = prog_inst.size() + RESET_CYCLES + 50;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset_n = 1'b1;
      foreach (prog_inst[i]) begin
         @(posedge clk);
         #1;
         i_inst       = prog_inst[i];
         i_inst_valid = prog_valid[i];
         // sampled next edge and shown on the port two edges later
         if (prog_valid[i] && !ref_halted) begin
            is_wwd = ref_execute(prog_inst[i], wwd_val, is_hlt);
            if (is_wwd) begin
               exp_val_q.push_back(wwd_val);
               exp_cyc_q.push_back(cyc + 3);
            end
            if (is_hlt) begin
               ref_halted = 1'b1;
               halt_cyc   = cyc + 3;
            end
         end
      end
      @(posedge clk);
      #1;
      i_inst_valid = 1'b0;
      wait (o_halted === 1'b1);
      repeat (DRAIN_CYCLES) @(negedge clk);
      if (exp_val_q.size() == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("%0d expected output values never appeared", exp_val_q.size());
         end_with_failure();
      end
   end

   // compare on the falling edge where outputs have settled
   // each strobe takes the oldest expected value
   always @(negedge clk) begin
      int due;
      if (reset_n) begin
         if (o_output_write === 1'b1) begin
            if (exp_val_q.size() == 0) begin
               $display("ERROR @ %0t: o_output_write pulsed with no value expected", $time);
               end_with_failure();
            end
            exp_port = exp_val_q.pop_front();
            due      = exp_cyc_q.pop_front();
            // strobe due two cycles after the sampling edge
            check_flag(o_output_write, cyc == due, "o_output_write");
         end else begin
            check_flag(o_output_write, 1'b0, "o_output_write");
         end
         check_word(o_output_port, exp_port, "o_output_port");
         check_flag(o_halted, cyc >= halt_cyc, "o_halted");
      end
   end

endmodule

// ==== compile.f ====
+incdir+tests
hw/cpu_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/id_stage.sv
hw/exec_stage.sv
hw/cpu_top.sv
tests/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
